// File: common/scaler_defines.svh
`ifndef SCALER_DEFINES_SVH
`define SCALER_DEFINES_SVH

// source image, both sizes even so each bank holds a full quarter
`define SRC_ROWS 8
`define SRC_COLS 12

// destination frame
`define DST_ROWS 15
`define DST_COLS 12

`define FRAC_BITS 8   // scale and weight fraction
`define PIX_W 8
`define COORD_W 16
`define SCALE_W 24

// one bank stores (SRC_ROWS/2)*(SRC_COLS/2) words
`define BANK_AW $clog2((`SRC_ROWS / 2) * (`SRC_COLS / 2))

`define MEM_LAT 2     // address to data, in cycles

`endif

// File: common/scaler_pkg.sv
`include "scaler_defines.svh"

package scaler_pkg;

	typedef logic [`PIX_W-1:0] pixel_t;

	// integer row or column index
	typedef logic [`COORD_W-1:0] coord_t;

	// source step per destination pixel, FRAC_BITS fraction bits
	typedef logic [`SCALE_W-1:0] scale_t;

	typedef logic [`FRAC_BITS-1:0] frac_t;       // blend weight
	typedef logic [`BANK_AW-1:0] bank_addr_t;    // word address in one bank

	// weighted product or sum of two pixels
	typedef logic [`PIX_W+`FRAC_BITS:0] blend_t;

	typedef enum logic {
		SCAN_IDLE,
		SCAN_RUN
	} scan_state_t;

endpackage

// File: coord_gen/pixel_scan.sv
`timescale 1ns/100ps
`include "scaler_defines.svh"

module pixel_scan (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	output logic               step,
	output scaler_pkg::coord_t dst_row,
	output scaler_pkg::coord_t dst_col,
	output logic               last
);
	import scaler_pkg::*;

	scan_state_t state;
	logic        start_d;      // start level of the previous cycle
	logic        start_edge;
	logic        col_end;
	logic        row_end;

	assign start_edge = start & ~start_d;
	assign col_end    = (dst_col == coord_t'(`DST_COLS - 1));
	assign row_end    = (dst_row == coord_t'(`DST_ROWS - 1));

	// one pixel per cycle for the whole frame
	assign step = (state == SCAN_RUN);
	assign last = step & row_end & col_end;

	always_ff @(posedge clk)
	begin
		if (rst)
			start_d <= 1'b0;
		else
			start_d <= start;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= SCAN_IDLE;
			dst_row <= '0;
			dst_col <= '0;
		end
		else
		begin
			case (state)
				SCAN_IDLE:
				begin
					if (start_edge)       // edges while running are dropped
						state <= SCAN_RUN;
				end
				SCAN_RUN:
				begin
					if (col_end)
					begin
						dst_col <= '0;
						dst_row <= row_end ? '0 : dst_row + 1'b1;
					end
					else
					begin
						dst_col <= dst_col + 1'b1;
					end
					if (row_end && col_end)
						state <= SCAN_IDLE;   // counters are already back at 0,0
				end
				default:
				begin
					state <= SCAN_IDLE;
				end
			endcase
		end
	end

endmodule

// File: coord_gen/neighbor_addr.sv
`timescale 1ns/100ps
`include "scaler_defines.svh"

module neighbor_addr (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   step,
	input  scaler_pkg::coord_t     dst_row,
	input  scaler_pkg::coord_t     dst_col,
	input  logic                   last,
	input  scaler_pkg::scale_t     scale_row,
	input  scaler_pkg::scale_t     scale_col,
	output logic                   bank_rd_en,
	output scaler_pkg::bank_addr_t bank_addr_ee,
	output scaler_pkg::bank_addr_t bank_addr_eo,
	output scaler_pkg::bank_addr_t bank_addr_oe,
	output scaler_pkg::bank_addr_t bank_addr_oo,
	output scaler_pkg::frac_t      row_frac,
	output scaler_pkg::frac_t      col_frac,
	output logic                   row_par,
	output logic                   col_par,
	output logic                   row_clamp,
	output logic                   col_clamp,
	output logic                   tag_last
);
	import scaler_pkg::*;

	localparam int PROD_W = `COORD_W + `SCALE_W;

	logic [PROD_W-1:0] row_prod;
	logic [PROD_W-1:0] col_prod;
	coord_t            r0;
	coord_t            r1;
	coord_t            c0;
	coord_t            c1;
	logic              r_clamp;
	logic              c_clamp;
	coord_t            row_ev;
	coord_t            row_od;
	coord_t            col_ev;
	coord_t            col_od;
	logic              row_ev_use;
	logic              col_ev_use;

	// word address inside a parity bank or 0 for an unread bank
	function automatic bank_addr_t word_addr(input coord_t r, input coord_t c, input logic used);
		coord_t lin;
		lin = (r >> 1) * coord_t'(`SRC_COLS / 2) + (c >> 1);
		return used ? bank_addr_t'(lin) : '0;
	endfunction

	assign row_prod = dst_row * scale_row;
	assign col_prod = dst_col * scale_col;
	assign r0       = row_prod[`FRAC_BITS +: `COORD_W];   // integer part
	assign c0       = col_prod[`FRAC_BITS +: `COORD_W];

	assign r_clamp = (r0 == coord_t'(`SRC_ROWS - 1));
	assign c_clamp = (c0 == coord_t'(`SRC_COLS - 1));
	assign r1      = r_clamp ? r0 : r0 + 1'b1;
	assign c1      = c_clamp ? c0 : c0 + 1'b1;

	// unclamped pairs always straddle both parities
	assign row_ev     = r0[0] ? r1 : r0;
	assign row_od     = r0[0] ? r0 : r1;
	assign col_ev     = c0[0] ? c1 : c0;
	assign col_od     = c0[0] ? c0 : c1;

	// the clamped index is odd so a clamp only ever drops an even bank
	assign row_ev_use = ~r0[0] | ~r_clamp;
	assign col_ev_use = ~c0[0] | ~c_clamp;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			bank_rd_en <= 1'b0;
			tag_last   <= 1'b0;
		end
		else
		begin
			bank_rd_en <= step;
			tag_last   <= last;
		end
	end

	always_ff @(posedge clk)
	begin
		bank_addr_ee <= word_addr(row_ev, col_ev, row_ev_use & col_ev_use);
		bank_addr_eo <= word_addr(row_ev, col_od, row_ev_use);
		bank_addr_oe <= word_addr(row_od, col_ev, col_ev_use);
		bank_addr_oo <= word_addr(row_od, col_od, 1'b1);
		row_frac     <= row_prod[`FRAC_BITS-1:0];
		col_frac     <= col_prod[`FRAC_BITS-1:0];
		row_par      <= r0[0];     // parity of the top-left neighbour
		col_par      <= c0[0];
		row_clamp    <= r_clamp;
		col_clamp    <= c_clamp;
	end

endmodule

// File: hdl/tap_delay.sv
`timescale 1ns/100ps
`include "scaler_defines.svh"

module tap_delay (
	input  logic              clk,
	input  logic              rst,
	input  logic              rd_en,
	input  scaler_pkg::frac_t row_frac,
	input  scaler_pkg::frac_t col_frac,
	input  logic              row_par,
	input  logic              col_par,
	input  logic              row_clamp,
	input  logic              col_clamp,
	input  logic              last,
	output logic              rd_en_dly,
	output scaler_pkg::frac_t row_frac_dly,
	output scaler_pkg::frac_t col_frac_dly,
	output logic              row_par_dly,
	output logic              col_par_dly,
	output logic              row_clamp_dly,
	output logic              col_clamp_dly,
	output logic              last_dly
);
	localparam int DATA_W = 2 * `FRAC_BITS + 4;

	logic [1:0]        ctl_sr  [`MEM_LAT];   // {rd_en, last} per stage
	logic [DATA_W-1:0] data_sr [`MEM_LAT];   // fractions, parities, clamps

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `MEM_LAT; i++)
				ctl_sr[i] <= 2'b00;
		end
		else
		begin
			ctl_sr[0] <= {rd_en, last};
			for (int i = 1; i < `MEM_LAT; i++)
				ctl_sr[i] <= ctl_sr[i-1];
		end
	end

	always_ff @(posedge clk)
	begin
		data_sr[0] <= {row_frac, col_frac, row_par, col_par, row_clamp, col_clamp};
		for (int i = 1; i < `MEM_LAT; i++)
			data_sr[i] <= data_sr[i-1];
	end

	// last stage lines up with the bank data of the same pixel
	assign {rd_en_dly, last_dly} = ctl_sr[`MEM_LAT-1];
	assign {row_frac_dly, col_frac_dly, row_par_dly, col_par_dly,
		row_clamp_dly, col_clamp_dly} = data_sr[`MEM_LAT-1];

endmodule

// File: interp/bilinear_interp.sv
`timescale 1ns/100ps
`include "scaler_defines.svh"

module bilinear_interp (
	input  logic               clk,
	input  logic               rst,
	input  scaler_pkg::pixel_t bank_data_ee,
	input  scaler_pkg::pixel_t bank_data_eo,
	input  scaler_pkg::pixel_t bank_data_oe,
	input  scaler_pkg::pixel_t bank_data_oo,
	input  logic               rd_en,
	input  scaler_pkg::frac_t  row_frac,
	input  scaler_pkg::frac_t  col_frac,
	input  logic               row_par,
	input  logic               col_par,
	input  logic               row_clamp,
	input  logic               col_clamp,
	input  logic               last,
	output scaler_pkg::pixel_t pix,
	output logic               pix_valid,
	output logic               finish
);
	import scaler_pkg::*;

	pixel_t bank_word [4];   // indexed by {row parity, col parity}
	logic   bot_par;
	logic   right_par;

	pixel_t nb_a;            // top-left
	pixel_t nb_b;            // top-right
	pixel_t nb_c;            // bottom-left
	pixel_t nb_d;            // bottom-right
	frac_t  row_frac_s1;
	frac_t  col_frac_s1;
	logic   valid_s1;
	logic   last_s1;

	pixel_t left_s2;
	pixel_t right_s2;
	frac_t  col_frac_s2;
	logic   valid_s2;
	logic   last_s2;

	logic   last_s3;

	// (S-f)*p0 + f*p1, scaled back to a pixel
	function automatic pixel_t blend(input pixel_t p0, input pixel_t p1, input frac_t f);
		logic [`FRAC_BITS:0] w0;
		blend_t              acc;
		w0  = {1'b1, {`FRAC_BITS{1'b0}}} - f;
		acc = w0 * p0 + f * p1;
		return pixel_t'(acc >> `FRAC_BITS);
	endfunction

	assign bank_word[0] = bank_data_ee;
	assign bank_word[1] = bank_data_eo;
	assign bank_word[2] = bank_data_oe;
	assign bank_word[3] = bank_data_oo;

	// a clamped side reuses the top or left bank
	assign bot_par   = row_clamp ? row_par : ~row_par;
	assign right_par = col_clamp ? col_par : ~col_par;

	always_ff @(posedge clk)
	begin
		nb_a        <= bank_word[{row_par, col_par}];
		nb_b        <= bank_word[{row_par, right_par}];
		nb_c        <= bank_word[{bot_par, col_par}];
		nb_d        <= bank_word[{bot_par, right_par}];
		row_frac_s1 <= row_frac;
		col_frac_s1 <= col_frac;

		left_s2     <= blend(nb_a, nb_c, row_frac_s1);   // vertical pass
		right_s2    <= blend(nb_b, nb_d, row_frac_s1);
		col_frac_s2 <= col_frac_s1;

		pix         <= blend(left_s2, right_s2, col_frac_s2);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_s1  <= 1'b0;
			last_s1   <= 1'b0;
			valid_s2  <= 1'b0;
			last_s2   <= 1'b0;
			pix_valid <= 1'b0;
			last_s3   <= 1'b0;
			finish    <= 1'b0;
		end
		else
		begin
			valid_s1  <= rd_en;
			last_s1   <= rd_en & last;
			valid_s2  <= valid_s1;
			last_s2   <= last_s1;
			pix_valid <= valid_s2;
			last_s3   <= last_s2;
			finish    <= last_s3;    // cycle after the final pixel
		end
	end

endmodule

// File: hdl/scaler_top.sv
`timescale 1ns/100ps
`include "scaler_defines.svh"

module scaler_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  scaler_pkg::scale_t     scale_row,
	input  scaler_pkg::scale_t     scale_col,
	input  scaler_pkg::pixel_t     bank_data_ee,
	input  scaler_pkg::pixel_t     bank_data_eo,
	input  scaler_pkg::pixel_t     bank_data_oe,
	input  scaler_pkg::pixel_t     bank_data_oo,
	output logic                   bank_rd_en,
	output scaler_pkg::bank_addr_t bank_addr_ee,
	output scaler_pkg::bank_addr_t bank_addr_eo,
	output scaler_pkg::bank_addr_t bank_addr_oe,
	output scaler_pkg::bank_addr_t bank_addr_oo,
	output scaler_pkg::pixel_t     pix,
	output logic                   pix_valid,
	output logic                   finish
);
	import scaler_pkg::*;

	logic   step;
	coord_t dst_row;
	coord_t dst_col;
	logic   scan_last;

	// per-pixel control leaving the address stage
	frac_t  row_frac;
	frac_t  col_frac;
	logic   row_par;
	logic   col_par;
	logic   row_clamp;
	logic   col_clamp;
	logic   tag_last;

	// same control, aligned with the returning bank data
	logic   rd_en_dly;
	frac_t  row_frac_dly;
	frac_t  col_frac_dly;
	logic   row_par_dly;
	logic   col_par_dly;
	logic   row_clamp_dly;
	logic   col_clamp_dly;
	logic   last_dly;

	pixel_scan i_pixel_scan (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.step    (step),
		.dst_row (dst_row),
		.dst_col (dst_col),
		.last    (scan_last)
	);

	neighbor_addr i_neighbor_addr (
		.clk          (clk),
		.rst          (rst),
		.step         (step),
		.dst_row      (dst_row),
		.dst_col      (dst_col),
		.last         (scan_last),
		.scale_row    (scale_row),
		.scale_col    (scale_col),
		.bank_rd_en   (bank_rd_en),
		.bank_addr_ee (bank_addr_ee),
		.bank_addr_eo (bank_addr_eo),
		.bank_addr_oe (bank_addr_oe),
		.bank_addr_oo (bank_addr_oo),
		.row_frac     (row_frac),
		.col_frac     (col_frac),
		.row_par      (row_par),
		.col_par      (col_par),
		.row_clamp    (row_clamp),
		.col_clamp    (col_clamp),
		.tag_last     (tag_last)
	);

	tap_delay i_tap_delay (
		.clk           (clk),
		.rst           (rst),
		.rd_en         (bank_rd_en),
		.row_frac      (row_frac),
		.col_frac      (col_frac),
		.row_par       (row_par),
		.col_par       (col_par),
		.row_clamp     (row_clamp),
		.col_clamp     (col_clamp),
		.last          (tag_last),
		.rd_en_dly     (rd_en_dly),
		.row_frac_dly  (row_frac_dly),
		.col_frac_dly  (col_frac_dly),
		.row_par_dly   (row_par_dly),
		.col_par_dly   (col_par_dly),
		.row_clamp_dly (row_clamp_dly),
		.col_clamp_dly (col_clamp_dly),
		.last_dly      (last_dly)
	);

	bilinear_interp i_bilinear_interp (
		.clk          (clk),
		.rst          (rst),
		.bank_data_ee (bank_data_ee),
		.bank_data_eo (bank_data_eo),
		.bank_data_oe (bank_data_oe),
		.bank_data_oo (bank_data_oo),
		.rd_en        (rd_en_dly),
		.row_frac     (row_frac_dly),
		.col_frac     (col_frac_dly),
		.row_par      (row_par_dly),
		.col_par      (col_par_dly),
		.row_clamp    (row_clamp_dly),
		.col_clamp    (col_clamp_dly),
		.last         (last_dly),
		.pix          (pix),
		.pix_valid    (pix_valid),
		.finish       (finish)
	);

endmodule

// File: verif/src_banks.sv
`timescale 1ns/100ps
`include "scaler_defines.svh"

module src_banks (
	input  logic                   clk,
	input  logic                   rd_en,
	input  scaler_pkg::bank_addr_t addr_ee,
	input  scaler_pkg::bank_addr_t addr_eo,
	input  scaler_pkg::bank_addr_t addr_oe,
	input  scaler_pkg::bank_addr_t addr_oo,
	input  logic                   wr_en,
	input  scaler_pkg::coord_t     wr_row,
	input  scaler_pkg::coord_t     wr_col,
	input  scaler_pkg::pixel_t     wr_data,
	output scaler_pkg::pixel_t     data_ee,
	output scaler_pkg::pixel_t     data_eo,
	output scaler_pkg::pixel_t     data_oe,
	output scaler_pkg::pixel_t     data_oo
);
	import scaler_pkg::*;

	localparam int DEPTH = (`SRC_ROWS / 2) * (`SRC_COLS / 2);

	pixel_t              mem [4][DEPTH];     // bank index {row parity, col parity}
	logic [4*`PIX_W-1:0] rd_pipe [`MEM_LAT];
	coord_t              wr_word;

	assign wr_word = (wr_row >> 1) * coord_t'(`SRC_COLS / 2) + (wr_col >> 1);

	initial
	begin
		for (int i = 0; i < `MEM_LAT; i++)
			rd_pipe[i] = '0;
	end

	always @(posedge clk)
	begin
		if (wr_en)
			mem[{wr_row[0], wr_col[0]}][wr_word] <= wr_data;
	end

	// first stage reads the array, the rest only delay
	always @(posedge clk)
	begin
		if (rd_en)
			rd_pipe[0] <= {mem[3][addr_oo], mem[2][addr_oe], mem[1][addr_eo], mem[0][addr_ee]};
		for (int i = 1; i < `MEM_LAT; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

	assign {data_oo, data_oe, data_eo, data_ee} = rd_pipe[`MEM_LAT-1];

endmodule

// File: verif/tb_scaler.sv
`timescale 1ns/100ps
`include "scaler_defines.svh"

module tb_scaler;
	import scaler_pkg::*;

	localparam int TOTAL = `DST_ROWS * `DST_COLS;
	localparam int S     = 1 << `FRAC_BITS;

	logic       clk;
	logic       rst;
	logic       start;
	scale_t     scale_row;
	scale_t     scale_col;
	pixel_t     bank_data_ee;
	pixel_t     bank_data_eo;
	pixel_t     bank_data_oe;
	pixel_t     bank_data_oo;
	logic       bank_rd_en;
	bank_addr_t bank_addr_ee;
	bank_addr_t bank_addr_eo;
	bank_addr_t bank_addr_oe;
	bank_addr_t bank_addr_oo;
	pixel_t     pix;
	logic       pix_valid;
	logic       finish;

	logic       wr_en;
	coord_t     wr_row;
	coord_t     wr_col;
	pixel_t     wr_data;

	pixel_t     img [`SRC_ROWS][`SRC_COLS];   // copy of the source banks
	integer     seed;
	int         frames_started;
	int         finish_cnt;
	int         pix_cnt;          // pixels of the current frame
	int         total_pix;
	int         cyc_cnt;
	int         rd_idx;
	int         val_idx;
	int         last_valid_cyc;
	int         rd_cyc [16];      // ring of read cycles

	scaler_top i_scaler_top (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.scale_row    (scale_row),
		.scale_col    (scale_col),
		.bank_data_ee (bank_data_ee),
		.bank_data_eo (bank_data_eo),
		.bank_data_oe (bank_data_oe),
		.bank_data_oo (bank_data_oo),
		.bank_rd_en   (bank_rd_en),
		.bank_addr_ee (bank_addr_ee),
		.bank_addr_eo (bank_addr_eo),
		.bank_addr_oe (bank_addr_oe),
		.bank_addr_oo (bank_addr_oo),
		.pix          (pix),
		.pix_valid    (pix_valid),
		.finish       (finish)
	);

	src_banks i_src_banks (
		.clk     (clk),
		.rd_en   (bank_rd_en),
		.addr_ee (bank_addr_ee),
		.addr_eo (bank_addr_eo),
		.addr_oe (bank_addr_oe),
		.addr_oo (bank_addr_oo),
		.wr_en   (wr_en),
		.wr_row  (wr_row),
		.wr_col  (wr_col),
		.wr_data (wr_data),
		.data_ee (bank_data_ee),
		.data_eo (bank_data_eo),
		.data_oe (bank_data_oe),
		.data_oo (bank_data_oo)
	);

	always #5 clk = ~clk;

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// top-left neighbour inside the image
	function automatic bit in_source(input int i, input int j);
		return ((i * int'(scale_row)) >> `FRAC_BITS) <= `SRC_ROWS - 1 &&
			((j * int'(scale_col)) >> `FRAC_BITS) <= `SRC_COLS - 1;
	endfunction

	// expected output for destination pixel (i,j)
	function automatic int ref_pixel(input int i, input int j);
		int rp;
		int cp;
		int r0;
		int r1;
		int c0;
		int c1;
		int rf;
		int cf;
		int left;
		int right;
		rp    = i * int'(scale_row);
		cp    = j * int'(scale_col);
		r0    = rp >> `FRAC_BITS;
		c0    = cp >> `FRAC_BITS;
		rf    = rp % S;
		cf    = cp % S;
		r1    = (r0 == `SRC_ROWS - 1) ? r0 : r0 + 1;   // bottom border
		c1    = (c0 == `SRC_COLS - 1) ? c0 : c0 + 1;   // right border
		left  = ((S - rf) * int'(img[r0][c0]) + rf * int'(img[r1][c0])) >> `FRAC_BITS;
		right = ((S - rf) * int'(img[r0][c1]) + rf * int'(img[r1][c1])) >> `FRAC_BITS;
		return ((S - cf) * left + cf * right) >> `FRAC_BITS;
	endfunction

	// expected address of bank {row parity, col parity} for pixel (i,j)
	function automatic int bank_addr_ref(input int i, input int j, input int bank);
		int rows [2];
		int cols [2];
		int addr;
		rows[0] = (i * int'(scale_row)) >> `FRAC_BITS;
		cols[0] = (j * int'(scale_col)) >> `FRAC_BITS;
		rows[1] = (rows[0] == `SRC_ROWS - 1) ? rows[0] : rows[0] + 1;
		cols[1] = (cols[0] == `SRC_COLS - 1) ? cols[0] : cols[0] + 1;
		addr    = 0;   // bank that holds no neighbour
		for (int a = 0; a < 2; a++)
			for (int b = 0; b < 2; b++)
				if ((rows[a] % 2) * 2 + (cols[b] % 2) == bank)
					addr = (rows[a] / 2) * (`SRC_COLS / 2) + cols[b] / 2;
		return addr;
	endfunction

	task automatic compare_bank_addrs(input int i, input int j);
		// rows past the source under unit scale have no defined address
		if (in_source(i, j))
		begin
			check_value("bank_addr_ee", bank_addr_ee, bank_addr_ref(i, j, 0));
			check_value("bank_addr_eo", bank_addr_eo, bank_addr_ref(i, j, 1));
			check_value("bank_addr_oe", bank_addr_oe, bank_addr_ref(i, j, 2));
			check_value("bank_addr_oo", bank_addr_oo, bank_addr_ref(i, j, 3));
		end
	endtask

	task automatic load_image(input bit random_fill);
		pixel_t value;
		for (int r = 0; r < `SRC_ROWS; r++)
		begin
			for (int c = 0; c < `SRC_COLS; c++)
			begin
				@(posedge clk);
				if (random_fill)
					value = pixel_t'($random(seed));
				else
					value = pixel_t'((r << 4) + c) ^ 8'h35;   // unique per position
				wr_en     <= 1'b1;
				wr_row    <= coord_t'(r);
				wr_col    <= coord_t'(c);
				wr_data   <= value;
				img[r][c] <= value;
			end
		end
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			check_value("bank_rd_en", bank_rd_en, 0);
			check_value("pix_valid", pix_valid, 0);
			check_value("finish", finish, 0);
		end
	endtask

	task automatic wait_first_pixel(input int seen);
		int cycles;
		cycles = 0;
		while (total_pix == seen)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > 16)
				stop_on_error("timeout waiting for the first pixel of a frame");
		end
	endtask

	task automatic wait_frame_end(input int target);
		int cycles;
		cycles = 0;
		while (finish_cnt < target)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > TOTAL + 32)
				stop_on_error("timeout waiting for finish");
		end
	endtask

	// optional second start edge lands in the middle of the scan
	task automatic run_frame(input int srow, input int scol, input bit double_start);
		int target;
		int seen;
		target = frames_started + 1;
		seen   = total_pix;
		@(posedge clk);
		scale_row      <= scale_t'(srow);
		scale_col      <= scale_t'(scol);
		start          <= 1'b1;
		frames_started <= frames_started + 1;
		@(posedge clk);
		start <= 1'b0;
		wait_first_pixel(seen);
		if (double_start)
		begin
			repeat (20) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		wait_frame_end(target);
	endtask

	always @(posedge clk)
	begin
		int row;
		int col;
		int rd_pos;
		if (!rst)
		begin
			cyc_cnt <= cyc_cnt + 1;
			if (bank_rd_en)
			begin
				if (finish_cnt >= frames_started)
					stop_on_error("memory read with no frame started");
				rd_pos = rd_idx % TOTAL;   // raster position of this read
				compare_bank_addrs(rd_pos / `DST_COLS, rd_pos % `DST_COLS);
				rd_cyc[rd_idx % 16] <= cyc_cnt;
				rd_idx <= rd_idx + 1;
			end
			if (pix_valid)
			begin
				if (pix_cnt >= TOTAL)
					stop_on_error("more pixels than one frame holds");
				check_value("pix_valid latency", cyc_cnt - rd_cyc[val_idx % 16], `MEM_LAT + 3);
				row = pix_cnt / `DST_COLS;   // raster order
				col = pix_cnt % `DST_COLS;
				// unit scale runs past the source rows so those pixels are only counted
				if (in_source(row, col))
				begin
					check_value("pix", pix, ref_pixel(row, col));
					if (scale_row == S && scale_col == S)
						check_value("pix", pix, img[row][col]);
					if (scale_row == 0 && scale_col == 0)
						check_value("pix", pix, img[0][0]);
				end
				pix_cnt        <= pix_cnt + 1;
				total_pix      <= total_pix + 1;
				val_idx        <= val_idx + 1;
				last_valid_cyc <= cyc_cnt;
			end
			if (finish)
			begin
				check_value("pixel count", pix_cnt, TOTAL);
				check_value("finish delay", cyc_cnt - last_valid_cyc, 1);
				finish_cnt <= finish_cnt + 1;
				pix_cnt    <= 0;
			end
		end
	end

	initial
	begin
		int srow;
		int scol;
		clk            = 1'b0;
		rst            = 1'b1;
		start          = 1'b0;
		scale_row      = '0;
		scale_col      = '0;
		wr_en          = 1'b0;
		wr_row         = '0;
		wr_col         = '0;
		wr_data        = '0;
		seed           = 32'h843b;
		frames_started = 0;
		finish_cnt     = 0;
		pix_cnt        = 0;
		total_pix      = 0;
		cyc_cnt        = 0;
		rd_idx         = 0;
		val_idx        = 0;
		last_valid_cyc = 0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		check_idle(10);

		load_image(1'b0);
		run_frame(S, S, 1'b0);
		run_frame(S / 2, S, 1'b1);   // last row and column hit the border

		repeat (3)
		begin
			load_image(1'b1);
			srow = int'($unsigned($random(seed)) % 129);   // r0 stays within 0..7
			scol = int'($unsigned($random(seed)) % 257);
			run_frame(srow, scol, 1'b0);
		end

		run_frame(0, 0, 1'b0);
		check_idle(20);
		check_value("frames finished", finish_cnt, frames_started);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: tb.f
+incdir+common
common/scaler_pkg.sv
coord_gen/pixel_scan.sv
coord_gen/neighbor_addr.sv
hdl/tap_delay.sv
interp/bilinear_interp.sv
hdl/scaler_top.sv
verif/src_banks.sv
verif/tb_scaler.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the scaler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_scaler \
	-f tb.f \
	-o sim_scaler

./obj_dir/sim_scaler
